// File: rotate_core.f
rot_pkg.sv
rot_if.sv
rot_geometry.sv
tile_sequencer.sv
rot_addr_unit.sv
bus_addr_select.sv
rotate_core.sv
rotate_core_chk.sv
rotate_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rotate_core_tb
FILELIST  = rotate_core.f
RUNFLAGS  = +verilator+error+limit+100000
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -qx "No errors" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rotate_core_tb.sv
`timescale 1ns/10ps

module rotate_core_tb;

	logic            I_CS_HCLK;
	logic            I_CS_HRESET_N;
	logic            start;
	rot_pkg::dim_t   height;
	rot_pkg::dim_t   width;
	rot_pkg::angle_t degrees;
	logic            direction;
	logic            dma_ready;
	rot_pkg::addr_t  addr;
	rot_pkg::addr_t  dst_img;
	rot_pkg::dim_t   new_h;
	rot_pkg::dim_t   new_w;
	logic            write;
	logic            busy;
	logic            imem_pad;
	logic            intr_done;

	logic [31:0] lfsr = 32'h89a4;
	int          timeouts = 0;

	rotate_core DUT (.*);

	bind rotate_core rotate_core_chk u_chk (
		.I_CS_HCLK     (I_CS_HCLK),
		.I_CS_HRESET_N (I_CS_HRESET_N),
		.start         (start),
		.height        (height),
		.width         (width),
		.degrees       (degrees),
		.direction     (direction),
		.dma_ready     (dma_ready),
		.addr          (addr),
		.dst_img       (dst_img),
		.new_h         (new_h),
		.new_w         (new_w),
		.write         (write),
		.busy          (busy),
		.imem_pad      (imem_pad),
		.intr_done     (intr_done)
	);

	always #20 I_CS_HCLK = ~I_CS_HCLK;

	// galois lfsr with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	// runs until intr_done rises, with a stray start in the middle
	task automatic wait_done(input logic ready_random, input int limit);
		int          n;
		logic [31:0] r;
		n = 0;
		do begin
			@(posedge I_CS_HCLK);
			r = take_bits(1);
			dma_ready <= ready_random ? r[0] : 1'b1;
			if (n == 20) begin
				start  <= 1'b1;  // must be ignored while busy
				height <= rot_pkg::dim_t'(take_bits(6));
				width  <= rot_pkg::dim_t'(take_bits(6));
			end else begin
				start <= 1'b0;
			end
			n++;
		end while (!intr_done && n < limit);
		if (!intr_done) begin
			timeouts++;
			$display("timeout: intr_done did not rise within %0d cycles", limit);
		end
	endtask

	task automatic run_job(input int job);
		logic [31:0] h;
		logic [31:0] w;
		h = take_bits(6) % 40 + 1;
		w = take_bits(6) % 40 + 1;
		@(posedge I_CS_HCLK);
		start     <= 1'b1;
		height    <= rot_pkg::dim_t'(h);
		width     <= rot_pkg::dim_t'(w);
		degrees   <= rot_pkg::angle_t'(job % 4);
		direction <= job[2];
		dma_ready <= 1'b1;
		wait_done(job >= 8, 20000);  // second half with random stalls
		repeat (3) @(posedge I_CS_HCLK);
	endtask

	initial begin
		I_CS_HCLK     = 1'b0;
		I_CS_HRESET_N = 1'b0;
		start         = 1'b0;
		height        = '0;
		width         = '0;
		degrees       = rot_pkg::ANGLE_0;
		direction     = 1'b0;
		dma_ready     = 1'b1;
		repeat (4) @(posedge I_CS_HCLK);
		I_CS_HRESET_N <= 1'b1;
		for (int j = 0; j < 16; j++)
			run_job(j);
		$display("assertion failures: %0d, timeouts: %0d", DUT.u_chk.fail_count, timeouts);
		if (DUT.u_chk.fail_count == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: rotate_core_chk.sv
`timescale 1ns/10ps

module rotate_core_chk (
	input logic            I_CS_HCLK,
	input logic            I_CS_HRESET_N,
	input logic            start,
	input rot_pkg::dim_t   height,
	input rot_pkg::dim_t   width,
	input rot_pkg::angle_t degrees,
	input logic            direction,
	input logic            dma_ready,
	input rot_pkg::addr_t  addr,
	input rot_pkg::addr_t  dst_img,
	input rot_pkg::dim_t   new_h,
	input rot_pkg::dim_t   new_w,
	input logic            write,
	input logic            busy,
	input logic            imem_pad,
	input logic            intr_done
);

	int             fail_count = 0;
	int             m_h, m_w, m_eff;           // job as latched on start
	int             m_beat, m_tile, m_cyc;     // beat position and cycles since start
	int             m_ph, m_pw, m_th, m_nh, m_nw, m_tiles;
	int             m_y, m_x, exp_row, exp_col;
	logic           m_wr;                      // model phase, high for write beats
	logic           m_stalled;
	logic           accept;
	logic           fire;
	logic           ccw_swap;
	logic           exp_pad;
	rot_pkg::addr_t exp_base;
	rot_pkg::addr_t exp_rd;
	rot_pkg::addr_t exp_wr;

	assign accept   = start && !busy;
	assign fire     = busy && dma_ready;
	assign ccw_swap = !direction
		&& (degrees == rot_pkg::ANGLE_90 || degrees == rot_pkg::ANGLE_270);

	always_ff @(posedge I_CS_HCLK) begin
		if (!I_CS_HRESET_N) begin
			m_h       <= 0;
			m_w       <= 0;
			m_eff     <= 0;
			m_beat    <= 0;
			m_tile    <= 0;
			m_cyc     <= 0;
			m_wr      <= 1'b0;
			m_stalled <= 1'b0;
		end else if (accept) begin
			m_h       <= int'(height);
			m_w       <= int'(width);
			m_eff     <= ccw_swap ? 4 - int'(degrees) : int'(degrees);
			m_beat    <= 0;
			m_tile    <= 0;
			m_cyc     <= 1;
			m_wr      <= 1'b0;
			m_stalled <= 1'b0;
		end else begin
			m_cyc <= m_cyc + 1;
			if (busy && !dma_ready)
				m_stalled <= 1'b1;
			if (fire) begin
				m_beat <= (m_beat + 1) % 64;
				if (m_beat == 63) begin
					m_wr <= !m_wr;
					if (m_wr)
						m_tile <= m_tile + 1;  // next tile after its write phase
				end
			end
		end
	end

	always_comb begin
		m_ph    = (m_h + 7) / 8 * 8;
		m_pw    = (m_w + 7) / 8 * 8;
		m_th    = (m_ph > 0) ? m_ph / 8 : 1;
		m_tiles = m_th * (m_pw / 8);
		m_nh    = m_eff[0] ? m_pw : m_ph;
		m_nw    = m_eff[0] ? m_ph : m_pw;
		m_y     = (m_tile % m_th) * 8 + m_beat / 8;  // tile rows first
		m_x     = (m_tile / m_th) * 8 + m_beat % 8;
		case (m_eff)
			1: begin
				exp_row = m_x;
				exp_col = m_ph - 1 - m_y;
			end
			2: begin
				exp_row = m_ph - 1 - m_y;
				exp_col = m_pw - 1 - m_x;
			end
			3: begin
				exp_row = m_pw - 1 - m_x;
				exp_col = m_y;
			end
			default: begin
				exp_row = m_y;
				exp_col = m_x;
			end
		endcase
		exp_base = rot_pkg::addr_t'(m_ph * m_pw * 3);
		exp_rd   = rot_pkg::addr_t'((m_y * m_pw + m_x) * 3);
		exp_wr   = exp_base + rot_pkg::addr_t'((exp_row * m_nw + exp_col) * 3);
		exp_pad  = (m_y >= m_h) || (m_x >= m_w);
	end

	a_geometry: assert property (@(posedge I_CS_HCLK) disable iff (!I_CS_HRESET_N)
		busy |-> new_h == rot_pkg::dim_t'(m_nh) && new_w == rot_pkg::dim_t'(m_nw)
			&& dst_img == exp_base)
		else begin
			fail_count++;
			$error("[ERROR] %0t geometry %0d x %0d base %0h", $time, new_h, new_w, dst_img);
		end

	a_phase: assert property (@(posedge I_CS_HCLK) disable iff (!I_CS_HRESET_N)
		busy |-> write == m_wr)
		else begin
			fail_count++;
			$error("[ERROR] %0t write %b, want %b", $time, write, m_wr);
		end

	a_read: assert property (@(posedge I_CS_HCLK) disable iff (!I_CS_HRESET_N)
		fire && !m_wr |-> addr == exp_rd && imem_pad == exp_pad)
		else begin
			fail_count++;
			$error("[ERROR] %0t read addr %0h pad %b, want %0h", $time, addr, imem_pad, exp_rd);
		end

	a_write: assert property (@(posedge I_CS_HCLK) disable iff (!I_CS_HRESET_N)
		fire && m_wr |-> addr == exp_wr && !imem_pad)
		else begin
			fail_count++;
			$error("[ERROR] %0t write addr %0h, want %0h", $time, addr, exp_wr);
		end

	a_stall: assert property (@(posedge I_CS_HCLK) disable iff (!I_CS_HRESET_N)
		busy && !dma_ready |-> !imem_pad ##1 ($stable(addr) && $stable(write)))
		else begin
			fail_count++;
			$error("[ERROR] %0t position moved while dma_ready was low", $time);
		end

	a_idle: assert property (@(posedge I_CS_HCLK) disable iff (!I_CS_HRESET_N)
		!busy |-> addr == '0 && !write && !imem_pad)
		else begin
			fail_count++;
			$error("[ERROR] %0t idle outputs not quiet, addr %0h", $time, addr);
		end

	a_done: assert property (@(posedge I_CS_HCLK) disable iff (!I_CS_HRESET_N)
		$rose(intr_done) |-> !busy && (m_stalled || m_cyc == 128 * m_tiles + 1))
		else begin
			fail_count++;
			$error("[ERROR] %0t done after %0d cycles, %0d tiles", $time, m_cyc, m_tiles);
		end

	a_start: assert property (@(posedge I_CS_HCLK) disable iff (!I_CS_HRESET_N)
		accept |=> busy && !intr_done)
		else begin
			fail_count++;
			$error("[ERROR] %0t start handling wrong, busy %b done %b", $time, busy, intr_done);
		end

	a_ignore: assert property (@(posedge I_CS_HCLK) disable iff (!I_CS_HRESET_N)
		start && busy |=> $stable(dst_img) && $stable(new_h) && $stable(new_w))
		else begin
			fail_count++;
			$error("[ERROR] %0t start while busy changed geometry %0d x %0d", $time,
				new_h, new_w);
		end

endmodule

// File: rotate_core.sv
`timescale 1ns/10ps

module rotate_core (
	input  logic            I_CS_HCLK,
	input  logic            I_CS_HRESET_N,
	input  logic            start,
	input  rot_pkg::dim_t   height,
	input  rot_pkg::dim_t   width,
	input  rot_pkg::angle_t degrees,
	input  logic            direction,
	input  logic            dma_ready,
	output rot_pkg::addr_t  addr,
	output rot_pkg::addr_t  dst_img,
	output rot_pkg::dim_t   new_h,
	output rot_pkg::dim_t   new_w,
	output logic            write,
	output logic            busy,
	output logic            imem_pad,
	output logic            intr_done
);

	geom_if  geom ();
	coord_if coord ();

	rot_pkg::addr_t unit_addr [rot_pkg::NUM_ANGLES];  // one per angle

	rot_geometry u_geometry (
		.I_CS_HCLK     (I_CS_HCLK),
		.I_CS_HRESET_N (I_CS_HRESET_N),
		.start         (start),
		.busy          (busy),
		.height        (height),
		.width         (width),
		.degrees       (degrees),
		.direction     (direction),
		.geom          (geom.source)
	);

	tile_sequencer u_sequencer (
		.I_CS_HCLK     (I_CS_HCLK),
		.I_CS_HRESET_N (I_CS_HRESET_N),
		.start         (start),
		.dma_ready     (dma_ready),
		.geom          (geom.sink),
		.coord         (coord.source),
		.busy          (busy),
		.write         (write),
		.imem_pad      (imem_pad),
		.intr_done     (intr_done)
	);

	for (genvar k = 0; k < rot_pkg::NUM_ANGLES; k++) begin : g_unit
		rot_addr_unit #(
			.ANGLE (k)
		) u_addr_unit (
			.geom    (geom.sink),
			.coord   (coord.sink),
			.wr_addr (unit_addr[k])
		);
	end

	bus_addr_select u_addr_select (
		.geom    (geom.sink),
		.coord   (coord.sink),
		.wr_addr (unit_addr),
		.addr    (addr)
	);

	// job geometry to the register file
	assign dst_img = geom.dst_base;
	assign new_h   = geom.new_h;
	assign new_w   = geom.new_w;

endmodule

// File: bus_addr_select.sv
`timescale 1ns/10ps

module bus_addr_select (
	geom_if.sink           geom,
	coord_if.sink          coord,
	input  rot_pkg::addr_t wr_addr [rot_pkg::NUM_ANGLES],
	output rot_pkg::addr_t addr
);

	rot_pkg::addr_t rd_addr;
	rot_pkg::addr_t rd_pixel;

	// row-major source image at byte 0
	assign rd_pixel = rot_pkg::addr_t'(coord.src_y) * rot_pkg::addr_t'(geom.pad_w)
		+ rot_pkg::addr_t'(coord.src_x);
	assign rd_addr  = rd_pixel * rot_pkg::addr_t'(rot_pkg::BYTES_PER_PIXEL);

	always_comb begin
		case (coord.state)
			rot_pkg::READ: begin
				addr = rd_addr;
			end
			rot_pkg::WRITE: begin
				addr = wr_addr[geom.eff_angle];  // unit for the effective angle
			end
			default: begin
				addr = '0;
			end
		endcase
	end

endmodule

// File: rot_addr_unit.sv
`timescale 1ns/10ps

module rot_addr_unit #(
	parameter int ANGLE = 0
) (
	geom_if.sink           geom,
	coord_if.sink          coord,
	output rot_pkg::addr_t wr_addr
);

	rot_pkg::dim_t dst_row;
	rot_pkg::dim_t dst_col;
	rot_pkg::dim_t last_y;
	rot_pkg::dim_t last_x;

	assign last_y = geom.pad_h - rot_pkg::dim_t'(1);
	assign last_x = geom.pad_w - rot_pkg::dim_t'(1);

	// destination row and column in the rotated image
	always_comb begin
		case (rot_pkg::angle_t'(ANGLE))
			rot_pkg::ANGLE_90: begin
				dst_row = coord.src_x;
				dst_col = last_y - coord.src_y;
			end
			rot_pkg::ANGLE_180: begin
				dst_row = last_y - coord.src_y;
				dst_col = last_x - coord.src_x;
			end
			rot_pkg::ANGLE_270: begin
				dst_row = last_x - coord.src_x;
				dst_col = coord.src_y;
			end
			default: begin
				dst_row = coord.src_y;
				dst_col = coord.src_x;
			end
		endcase
	end

	assign wr_addr = geom.dst_base
		+ (rot_pkg::addr_t'(dst_row) * rot_pkg::addr_t'(geom.new_w) + rot_pkg::addr_t'(dst_col))
		* rot_pkg::addr_t'(rot_pkg::BYTES_PER_PIXEL);

endmodule

// File: tile_sequencer.sv
`timescale 1ns/10ps

module tile_sequencer (
	input  logic    I_CS_HCLK,
	input  logic    I_CS_HRESET_N,
	input  logic    start,
	input  logic    dma_ready,
	geom_if.sink    geom,
	coord_if.source coord,
	output logic    busy,
	output logic    write,
	output logic    imem_pad,
	output logic    intr_done
);

	rot_pkg::seq_state_t state;
	rot_pkg::seq_state_t state_next;
	rot_pkg::beat_t      beat;
	rot_pkg::tile_idx_t  tile_row;
	rot_pkg::tile_idx_t  tile_col;
	logic                start_ok;
	logic                beat_last;
	logic                row_last;
	logic                col_last;
	logic                job_last;

	assign start_ok  = start && !busy;
	assign beat_last = (beat == rot_pkg::beat_t'(rot_pkg::TILE_BEATS - 1));
	assign row_last  = (tile_row == geom.tiles_h - 1'b1);
	assign col_last  = (tile_col == geom.tiles_w - 1'b1);
	assign job_last  = row_last && col_last;

	assign busy  = (state != rot_pkg::IDLE);
	assign write = (state == rot_pkg::WRITE);

	assign coord.state     = state;
	assign coord.beat_fire = busy && dma_ready;  // stall while dma not ready

	// pixel inside the tile, row-major over the beat index
	assign coord.src_y = rot_pkg::dim_t'(tile_row) * rot_pkg::dim_t'(rot_pkg::TILE_DIM)
		+ rot_pkg::dim_t'(beat / rot_pkg::TILE_DIM);
	assign coord.src_x = rot_pkg::dim_t'(tile_col) * rot_pkg::dim_t'(rot_pkg::TILE_DIM)
		+ rot_pkg::dim_t'(beat % rot_pkg::TILE_DIM);

	assign imem_pad = (state == rot_pkg::READ) && coord.beat_fire
		&& ((coord.src_y >= geom.height) || (coord.src_x >= geom.width));

	always_comb begin
		state_next = state;
		case (state)
			rot_pkg::IDLE: begin
				if (start_ok)
					state_next = rot_pkg::READ;
			end
			rot_pkg::READ: begin
				if (coord.beat_fire && beat_last)
					state_next = rot_pkg::WRITE;
			end
			rot_pkg::WRITE: begin
				if (coord.beat_fire && beat_last)
					state_next = job_last ? rot_pkg::IDLE : rot_pkg::READ;
			end
			default: begin
				state_next = rot_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge I_CS_HCLK) begin
		if (!I_CS_HRESET_N)
			state <= rot_pkg::IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge I_CS_HCLK) begin
		if (!I_CS_HRESET_N) begin
			beat     <= '0;
			tile_row <= '0;
			tile_col <= '0;
		end else if (start_ok) begin
			beat     <= '0;
			tile_row <= '0;
			tile_col <= '0;
		end else if (coord.beat_fire) begin
			beat <= beat + 1'b1;  // wraps into the next phase
			if (state == rot_pkg::WRITE && beat_last && !job_last) begin
				if (row_last) begin
					tile_row <= '0;
					tile_col <= tile_col + 1'b1;
				end else begin
					tile_row <= tile_row + 1'b1;  // tile row advances first
				end
			end
		end
	end

	// sticky until the next accepted start
	always_ff @(posedge I_CS_HCLK) begin
		if (!I_CS_HRESET_N)
			intr_done <= 1'b0;
		else if (start_ok)
			intr_done <= 1'b0;
		else if (state == rot_pkg::WRITE && coord.beat_fire && beat_last && job_last)
			intr_done <= 1'b1;
	end

endmodule

// File: rot_geometry.sv
`timescale 1ns/10ps

module rot_geometry (
	input  logic            I_CS_HCLK,
	input  logic            I_CS_HRESET_N,
	input  logic            start,
	input  logic            busy,
	input  rot_pkg::dim_t   height,
	input  rot_pkg::dim_t   width,
	input  rot_pkg::angle_t degrees,
	input  logic            direction,
	geom_if.source          geom
);

	rot_pkg::tile_idx_t tiles_h_d;
	rot_pkg::tile_idx_t tiles_w_d;
	rot_pkg::dim_t      pad_h_d;
	rot_pkg::dim_t      pad_w_d;
	rot_pkg::angle_t    eff_d;
	logic               quarter;
	logic               start_ok;

	assign start_ok = start && !busy;

	// ceil(dim / 8), then back to pixels
	assign tiles_h_d = height[15:3] + rot_pkg::tile_idx_t'(|height[2:0]);
	assign tiles_w_d = width[15:3] + rot_pkg::tile_idx_t'(|width[2:0]);
	assign pad_h_d   = {tiles_h_d, 3'b000};
	assign pad_w_d   = {tiles_w_d, 3'b000};

	always_comb begin
		eff_d = degrees;
		if (!direction && degrees == rot_pkg::ANGLE_90)
			eff_d = rot_pkg::ANGLE_270;  // counter-clockwise
		else if (!direction && degrees == rot_pkg::ANGLE_270)
			eff_d = rot_pkg::ANGLE_90;
	end

	assign quarter = (eff_d == rot_pkg::ANGLE_90) || (eff_d == rot_pkg::ANGLE_270);

	always_ff @(posedge I_CS_HCLK) begin
		if (!I_CS_HRESET_N) begin
			geom.height    <= '0;
			geom.width     <= '0;
			geom.pad_h     <= '0;
			geom.pad_w     <= '0;
			geom.new_h     <= '0;
			geom.new_w     <= '0;
			geom.tiles_h   <= '0;
			geom.tiles_w   <= '0;
			geom.dst_base  <= '0;
			geom.eff_angle <= rot_pkg::ANGLE_0;
		end else if (start_ok) begin
			geom.height    <= height;
			geom.width     <= width;
			geom.pad_h     <= pad_h_d;
			geom.pad_w     <= pad_w_d;
			geom.new_h     <= quarter ? pad_w_d : pad_h_d;  // swap on right angle
			geom.new_w     <= quarter ? pad_h_d : pad_w_d;
			geom.tiles_h   <= tiles_h_d;
			geom.tiles_w   <= tiles_w_d;
			geom.dst_base  <= rot_pkg::addr_t'(pad_h_d) * rot_pkg::addr_t'(pad_w_d)
				* rot_pkg::addr_t'(rot_pkg::BYTES_PER_PIXEL);
			geom.eff_angle <= eff_d;
		end
	end

endmodule

// File: rot_if.sv
`timescale 1ns/10ps

// job geometry, latched once per run
interface geom_if;
	rot_pkg::dim_t      height;
	rot_pkg::dim_t      width;
	rot_pkg::dim_t      pad_h;
	rot_pkg::dim_t      pad_w;
	rot_pkg::dim_t      new_h;
	rot_pkg::dim_t      new_w;
	rot_pkg::tile_idx_t tiles_h;
	rot_pkg::tile_idx_t tiles_w;
	rot_pkg::addr_t     dst_base;
	rot_pkg::angle_t    eff_angle;

	modport source (
		output height, width, pad_h, pad_w, new_h, new_w,
		output tiles_h, tiles_w, dst_base, eff_angle
	);

	modport sink (
		input height, width, pad_h, pad_w, new_h, new_w,
		input tiles_h, tiles_w, dst_base, eff_angle
	);
endinterface

// current source pixel and phase
interface coord_if;
	rot_pkg::dim_t       src_y;
	rot_pkg::dim_t       src_x;
	rot_pkg::seq_state_t state;
	logic                beat_fire;

	modport source (
		output src_y, src_x, state, beat_fire
	);

	modport sink (
		input src_y, src_x, state, beat_fire
	);
endinterface

// File: rot_pkg.sv
package rot_pkg;

	// pixel dimension and bus address
	typedef logic [15:0] dim_t;
	typedef logic [31:0] addr_t;

	// tile row or column index, beat inside a tile
	typedef logic [12:0] tile_idx_t;
	typedef logic [5:0]  beat_t;

	localparam int TILE_DIM        = 8;   // pixels per tile side
	localparam int TILE_BEATS      = 64;  // beats per read or write phase
	localparam int BYTES_PER_PIXEL = 3;   // rgb
	localparam int NUM_ANGLES      = 4;

	// rotation angle in the encoding of the degrees input
	typedef enum logic [1:0] {
		ANGLE_0   = 2'd0,
		ANGLE_90  = 2'd1,
		ANGLE_180 = 2'd2,
		ANGLE_270 = 2'd3
	} angle_t;

	// sequencer phases
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		READ  = 2'd1,
		WRITE = 2'd2
	} seq_state_t;

endpackage
